//--- Makefile
TOP = exec_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import exec_pkg::*; (
    input  br_order_t br_in,
    output logic      taken
);

    // func3 codes of the conditional branches
    localparam logic [func3_w-1:0] f3_beq  = 3'd0;
    localparam logic [func3_w-1:0] f3_bne  = 3'd1;
    localparam logic [func3_w-1:0] f3_blt  = 3'd4;
    localparam logic [func3_w-1:0] f3_bge  = 3'd5;
    localparam logic [func3_w-1:0] f3_bltu = 3'd6;
    localparam logic [func3_w-1:0] f3_bgeu = 3'd7;

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    // shared comparators
    assign eq   = (br_in.rs1 == br_in.rs2);
    assign lt_s = ($signed(br_in.rs1) < $signed(br_in.rs2));
    assign lt_u = (br_in.rs1 < br_in.rs2);

    always_comb begin
        case (br_in.func3)
            f3_beq: begin
                cond = eq;
            end
            f3_bne: begin
                cond = ~eq;
            end
            f3_blt: begin
                cond = lt_s;
            end
            f3_bge: begin
                cond = ~lt_s;
            end
            f3_bltu: begin
                cond = lt_u;
            end
            f3_bgeu: begin
                cond = ~lt_u;
            end
            // 2 and 3 are not branches
            default: begin
                cond = 1'b0;
            end
        endcase
    end

    // jumps are always taken
    assign taken = (br_in.op == br_jump) ? 1'b1 : cond;

endmodule

//--- logic/exec_combine.sv
`timescale 1ns/1ps

module exec_combine import exec_pkg::*; #(
    parameter int write_para = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    input  br_order_t                   br_in,
    input  logic                        taken,
    input  write_d_r_t                  alu_out,
    output j_b_info_t                   j_b_info,
    output write_d_r_t [write_para-1:0] write_d_r
);

    logic              is_jump;
    logic              is_branch;
    logic [word_w-1:0] target;

    logic              jump_q;
    logic              branch_q;
    logic              hazard_q;
    logic [word_w-1:0] next_pc_q;
    logic [ctx_w-1:0]  ctx_q;

    logic              link_done_q;
    logic [preg_w-1:0] link_pa_rd_q;
    logic [word_w-1:0] link_rd_q;

    assign is_jump   = br_in.valid & (br_in.op == br_jump);
    assign is_branch = br_in.valid & (br_in.op == br_cond);

    // jump goes to rs1 + imm, branch to pc + imm
    assign target = (br_in.op == br_jump) ? br_in.rs1 + br_in.imm
                                          : br_in.pc + br_in.imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            jump_q      <= 1'b0;
            branch_q    <= 1'b0;
            hazard_q    <= 1'b0;
            link_done_q <= 1'b0;
        end else begin
            jump_q      <= is_jump;
            branch_q    <= is_branch;
            // a taken branch was predicted not taken
            hazard_q    <= is_branch & taken;
            link_done_q <= is_jump;
        end
    end

    always_ff @(posedge clk) begin
        next_pc_q    <= target;
        ctx_q        <= br_in.ctx;
        link_pa_rd_q <= br_in.pa_rd;
        link_rd_q    <= br_in.link;
    end

    assign j_b_info.jump    = jump_q;
    assign j_b_info.next_pc = next_pc_q;
    assign j_b_info.branch  = branch_q;
    assign j_b_info.ctx     = ctx_q;
    assign j_b_info.hazard  = hazard_q;

    // port 0 alu, port 1 jump link, the rest idle
    always_comb begin
        for (int i = 0; i < write_para; i++) begin
            write_d_r[i] = '0;
        end
        write_d_r[0]       = alu_out;
        write_d_r[1].done  = link_done_q;
        write_d_r[1].pa_rd = link_pa_rd_q;
        write_d_r[1].rd    = link_rd_q;
    end

endmodule

//--- logic/exec_pkg.sv
package exec_pkg;

    // data and tag widths
    localparam int word_w  = 32;
    localparam int preg_w  = 6;
    localparam int ctx_w   = 2;
    localparam int func3_w = 3;

    // integer lane operations
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9,
        op_copy = 4'd10
    } exec_op_e;

    // branch lane operations
    typedef enum logic {
        br_cond = 1'b0,
        br_jump = 1'b1
    } br_op_e;

    // issue to the integer lane
    typedef struct packed {
        logic              valid;
        exec_op_e          op;
        logic [preg_w-1:0] pa_rd;
        logic [word_w-1:0] rs1;
        logic [word_w-1:0] rs2;
    } alu_order_t;

    // issue to the branch lane
    // link is the return address written back on a jump
    typedef struct packed {
        logic               valid;
        br_op_e             op;
        logic [func3_w-1:0] func3;
        logic [word_w-1:0]  rs1;
        logic [word_w-1:0]  rs2;
        logic [word_w-1:0]  pc;
        logic [word_w-1:0]  imm;
        logic [word_w-1:0]  link;
        logic [preg_w-1:0]  pa_rd;
        logic [ctx_w-1:0]   ctx;
    } br_order_t;

    // write-back record for the register manager
    typedef struct packed {
        logic              done;
        logic [preg_w-1:0] pa_rd;
        logic [word_w-1:0] rd;
    } write_d_r_t;

    // jump/branch report for the context manager
    typedef struct packed {
        logic              jump;
        logic [word_w-1:0] next_pc;
        logic              branch;
        logic [ctx_w-1:0]  ctx;
        logic              hazard;
    } j_b_info_t;

endpackage

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import exec_pkg::*; #(
    parameter int write_para = 2
) (
    input  logic                        clk,
    input  logic                        reset,

    // from the issue window
    input  alu_order_t                  alu_in,
    input  br_order_t                   br_in,

    // to the context manager
    output j_b_info_t                   j_b_info,

    // to the register manager
    output write_d_r_t [write_para-1:0] write_d_r
);

    logic       taken;
    write_d_r_t alu_out;

    // branch lane
    branch_unit u_branch (
        .br_in (br_in),
        .taken (taken)
    );

    // integer lane
    int_alu u_alu (
        .clk     (clk),
        .reset   (reset),
        .alu_in  (alu_in),
        .alu_out (alu_out)
    );

    // results of both lanes
    exec_combine #(
        .write_para (write_para)
    ) u_combine (
        .clk       (clk),
        .reset     (reset),
        .br_in     (br_in),
        .taken     (taken),
        .alu_out   (alu_out),
        .j_b_info  (j_b_info),
        .write_d_r (write_d_r)
    );

endmodule

//--- logic/int_alu.sv
`timescale 1ns/1ps

module int_alu import exec_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  alu_order_t alu_in,
    output write_d_r_t alu_out
);

    logic [word_w-1:0] result;
    logic [4:0]        shamt;
    logic              done_q;
    logic [preg_w-1:0] pa_rd_q;
    logic [word_w-1:0] rd_q;

    // only the low five bits shift
    assign shamt = alu_in.rs2[4:0];

    always_comb begin
        case (alu_in.op)
            op_add: begin
                result = alu_in.rs1 + alu_in.rs2;
            end
            op_sub: begin
                result = alu_in.rs1 - alu_in.rs2;
            end
            op_and: begin
                result = alu_in.rs1 & alu_in.rs2;
            end
            op_or: begin
                result = alu_in.rs1 | alu_in.rs2;
            end
            op_xor: begin
                result = alu_in.rs1 ^ alu_in.rs2;
            end
            op_sll: begin
                result = alu_in.rs1 << shamt;
            end
            op_srl: begin
                result = alu_in.rs1 >> shamt;
            end
            op_sra: begin
                result = $unsigned($signed(alu_in.rs1) >>> shamt);
            end
            op_slt: begin
                result = {{(word_w-1){1'b0}},
                          ($signed(alu_in.rs1) < $signed(alu_in.rs2))};
            end
            op_sltu: begin
                result = {{(word_w-1){1'b0}}, (alu_in.rs1 < alu_in.rs2)};
            end
            // register copy
            op_copy: begin
                result = alu_in.rs1;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // done follows the order strobe by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= alu_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        pa_rd_q <= alu_in.pa_rd;
        rd_q    <= result;
    end

    assign alu_out.done  = done_q;
    assign alu_out.pa_rd = pa_rd_q;
    assign alu_out.rd    = rd_q;

endmodule

//--- verification/exec_asserts.sv
`timescale 1ns/1ps

module exec_asserts import exec_pkg::*; #(
    parameter int write_para = 2
) (
    input logic                        clk,
    input logic                        reset,
    input alu_order_t                  alu_in,
    input br_order_t                   br_in,
    input j_b_info_t                   j_b_info,
    input write_d_r_t [write_para-1:0] write_d_r
);

    // bumped by every failing assertion, watched from the testbench
    int fail_count = 0;

    logic quiet;

    always_comb begin
        quiet = !j_b_info.jump && !j_b_info.branch && !j_b_info.hazard;
        for (int i = 0; i < write_para; i++) begin
            if (write_d_r[i].done) begin
                quiet = 1'b0;
            end
        end
    end

    // signed less-than from the sign bits, magnitude when they agree
    function automatic logic less_signed(logic [word_w-1:0] a, logic [word_w-1:0] b);
        logic lt;
        if (a[word_w-1] != b[word_w-1]) begin
            lt = a[word_w-1];
        end else begin
            lt = (a < b);
        end
        return lt;
    endfunction

    function automatic logic [word_w-1:0] alu_expect(alu_order_t o);
        logic [4:0]        sh;
        logic [word_w-1:0] fill;
        logic [word_w-1:0] res;
        sh   = o.rs2[4:0];
        fill = {word_w{o.rs1[word_w-1]}};
        case (o.op)
            op_add:  res = o.rs1 + o.rs2;
            op_sub:  res = o.rs1 + ~o.rs2 + 1'b1;
            op_and:  res = o.rs1 & o.rs2;
            op_or:   res = o.rs1 | o.rs2;
            op_xor:  res = o.rs1 ^ o.rs2;
            op_sll:  res = o.rs1 << sh;
            op_srl:  res = o.rs1 >> sh;
            // logical shift, then the vacated top bits take the sign
            op_sra:  res = (o.rs1 >> sh) | (fill & ~({word_w{1'b1}} >> sh));
            op_slt:  res = {{(word_w-1){1'b0}}, less_signed(o.rs1, o.rs2)};
            op_sltu: res = {{(word_w-1){1'b0}}, (o.rs1 < o.rs2)};
            op_copy: res = o.rs1;
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic logic cond_expect(br_order_t o);
        logic c;
        case (o.func3)
            3'd0:    c = (o.rs1 == o.rs2);
            3'd1:    c = (o.rs1 != o.rs2);
            3'd4:    c = less_signed(o.rs1, o.rs2);
            3'd5:    c = !less_signed(o.rs1, o.rs2);
            3'd6:    c = (o.rs1 < o.rs2);
            3'd7:    c = (o.rs1 >= o.rs2);
            default: c = 1'b0;
        endcase
        return c;
    endfunction

    a_reset_quiet: assert property (@(posedge clk) reset |=> quiet)
        else begin
            fail_count++;
            $error("FAILED %0t: outputs active during or right after reset", $time);
        end

    a_alu_result: assert property (@(posedge clk) disable iff (reset)
        alu_in.valid |=> write_d_r[0].done
                         && write_d_r[0].pa_rd == $past(alu_in.pa_rd)
                         && write_d_r[0].rd == alu_expect($past(alu_in)))
        else begin
            fail_count++;
            $error("FAILED %0t: alu write-back record does not match the order", $time);
        end

    a_alu_idle: assert property (@(posedge clk) disable iff (reset)
        !alu_in.valid |=> !write_d_r[0].done)
        else begin
            fail_count++;
            $error("FAILED %0t: alu done set without an order", $time);
        end

    a_branch: assert property (@(posedge clk) disable iff (reset)
        (br_in.valid && br_in.op == br_cond) |=> j_b_info.branch && !j_b_info.jump
            && j_b_info.ctx == $past(br_in.ctx)
            && j_b_info.hazard == cond_expect($past(br_in))
            && j_b_info.next_pc == $past(br_in.pc) + $past(br_in.imm)
            && !write_d_r[1].done)
        else begin
            fail_count++;
            $error("FAILED %0t: branch report does not match the order", $time);
        end

    a_jump: assert property (@(posedge clk) disable iff (reset)
        (br_in.valid && br_in.op == br_jump) |=> j_b_info.jump && !j_b_info.branch
            && !j_b_info.hazard
            && j_b_info.next_pc == $past(br_in.rs1) + $past(br_in.imm)
            && write_d_r[1].done
            && write_d_r[1].pa_rd == $past(br_in.pa_rd)
            && write_d_r[1].rd == $past(br_in.link))
        else begin
            fail_count++;
            $error("FAILED %0t: jump report or link record does not match", $time);
        end

    a_br_idle: assert property (@(posedge clk) disable iff (reset)
        !br_in.valid |=> !j_b_info.jump && !j_b_info.branch && !j_b_info.hazard
                         && !write_d_r[1].done)
        else begin
            fail_count++;
            $error("FAILED %0t: branch lane output set without an order", $time);
        end

endmodule

//--- verification/exec_tb.sv
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

    localparam int write_para  = 2;
    localparam int run_cycles  = 400;
    localparam int drain_limit = 20;

    logic                        clk;
    logic                        reset;
    alu_order_t                  alu_in;
    br_order_t                   br_in;
    j_b_info_t                   j_b_info;
    write_d_r_t [write_para-1:0] write_d_r;

    int seed;
    int drain_cycles;

    exec_unit #(
        .write_para (write_para)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .alu_in    (alu_in),
        .br_in     (br_in),
        .j_b_info  (j_b_info),
        .write_d_r (write_d_r)
    );

    bind exec_unit exec_asserts #(
        .write_para (write_para)
    ) u_asserts (
        .clk       (clk),
        .reset     (reset),
        .alu_in    (alu_in),
        .br_in     (br_in),
        .j_b_info  (j_b_info),
        .write_d_r (write_d_r)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic report_failure(input string why);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", why);
    endtask

    // small values, sign bit patterns and plain random words
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        logic [31:0] v;
        logic [31:0] res;
        r = $random(seed);
        v = $random(seed);
        case (r[2:0])
            3'd0:    res = {28'd0, v[3:0]};
            3'd1:    res = {1'b1, v[30:0]};
            3'd2:    res = 32'h8000_0000;
            3'd3:    res = 32'hffff_ffff;
            default: res = v;
        endcase
        return res;
    endfunction

    task automatic drive_orders();
        logic [31:0] r;
        logic [31:0] v;
        logic [7:0]  sel;
        alu_order_t  a;
        br_order_t   b;
        r       = $random(seed);
        sel     = r[11:4] % 8'd11;
        a.valid = (r[3:0] != 4'd0);
        a.op    = exec_op_e'(sel[3:0]);
        a.pa_rd = r[17:12];
        a.rs1   = pick_operand();
        // equal operands about one time in four
        a.rs2   = (r[19:18] == 2'd0) ? a.rs1 : pick_operand();

        r       = $random(seed);
        v       = $random(seed);
        b.valid = (r[3:0] != 4'd0);
        b.op    = (r[5:4] == 2'd0) ? br_jump : br_cond;
        b.func3 = r[8:6];
        b.pa_rd = r[14:9];
        b.ctx   = r[16:15];
        b.rs1   = pick_operand();
        b.rs2   = (r[18:17] == 2'd0) ? b.rs1 : pick_operand();
        b.pc    = {v[31:2], 2'b00};
        b.imm   = pick_operand();
        b.link  = b.pc + 32'd4;

        alu_in <= a;
        br_in  <= b;
    endtask

    function automatic logic outputs_busy();
        logic busy;
        busy = j_b_info.jump | j_b_info.branch | j_b_info.hazard;
        for (int i = 0; i < write_para; i++) begin
            busy = busy | write_d_r[i].done;
        end
        return busy;
    endfunction

    // stop at the first assertion failure
    always @(negedge clk) begin
        if (uut.u_asserts.fail_count != 0) begin
            report_failure("an assertion on the DUT outputs failed");
        end
    end

    initial begin
        seed   = 69;
        reset  = 1'b1;
        alu_in = '0;
        br_in  = '0;

        // orders during reset must not reach the outputs
        repeat (5) begin
            @(posedge clk);
            drive_orders();
        end
        reset <= 1'b0;

        repeat (run_cycles) begin
            @(posedge clk);
            drive_orders();
        end

        @(posedge clk);
        alu_in <= '0;
        br_in  <= '0;

        // let the last results leave the stage
        drain_cycles = 0;
        @(negedge clk);
        while (outputs_busy() && drain_cycles < drain_limit) begin
            @(negedge clk);
            drain_cycles++;
        end

        if (outputs_busy()) begin
            report_failure("outputs still active after the drain timeout");
        end else if (uut.u_asserts.fail_count != 0) begin
            report_failure("assertion failures were counted during the run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- verilog.f
logic/exec_pkg.sv
logic/branch_unit.sv
logic/int_alu.sv
logic/exec_combine.sv
logic/exec_unit.sv
verification/exec_asserts.sv
verification/exec_tb.sv
